/* icacheConsts.svh */
// cache geometry for a word-addressed fetch path; offset, index and tag widths must sum to 32
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// number of cache lines, direct mapped
`define ICACHE_LINES 128

// instructions per line
`define ICACHE_WORDS 16

// width of one instruction word
`define ICACHE_WORD_BITS 32

// whole line, ICACHE_WORDS * ICACHE_WORD_BITS
`define ICACHE_LINE_BITS 512

// word address width seen by the core and the memory
`define ICACHE_ADDR_BITS 32

// address fields, low to high: offset, index, tag
`define ICACHE_OFFSET_BITS 4
`define ICACHE_INDEX_BITS 7
`define ICACHE_TAG_BITS 21

`endif

/* icachePkg.sv */
// fetch address types only; field widths come from icacheConsts.svh and assume word addressing
`include "icacheConsts.svh"

package icachePkg;

    // word address split into cache fields
    // tag sits in the high bits, offset in the low bits
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0]    tag;
        logic [`ICACHE_INDEX_BITS-1:0]  index;
        logic [`ICACHE_OFFSET_BITS-1:0] offset;
    } fetchFields;

    // same 32 bits, read either as a plain word address
    // or decoded into tag, index and offset
    typedef union packed {
        logic [`ICACHE_ADDR_BITS-1:0] raw;
        fetchFields                   f;
    } fetchAddr;

endpackage

/* iCache.sv */
// direct-mapped, read-only; never a lookup and a load in the same cycle, data/tags not reset
`timescale 1ns/100ps
`include "icacheConsts.svh"

module iCache (
    input  logic                         clk,
    input  logic                         reset,
    // lookup port, result one cycle later
    input  logic                         lookupEn,
    input  icachePkg::fetchAddr          lookupAddr,
    // whole-line load port from the refill side
    input  logic                         loadLine,
    input  icachePkg::fetchAddr          loadAddr,
    input  logic [`ICACHE_LINE_BITS-1:0] loadData,
    // registered lookup result
    output logic [`ICACHE_WORD_BITS-1:0] instrOut,
    output logic                         hit,
    output logic                         miss
);

    // storage arrays, one entry per line
    logic [`ICACHE_LINE_BITS-1:0] dataArray [`ICACHE_LINES];
    logic [`ICACHE_TAG_BITS-1:0]  tagArray  [`ICACHE_LINES];
    // one valid bit per line, the only state cleared by reset
    logic [`ICACHE_LINES-1:0]     validBits;

    // read side of the lookup
    logic [`ICACHE_LINE_BITS-1:0] lineRd;
    logic [`ICACHE_TAG_BITS-1:0]  tagRd;
    logic [`ICACHE_WORD_BITS-1:0] wordRd;
    logic                         tagMatch;

    // the array read is combinational, the result is flopped below
    assign lineRd = dataArray[lookupAddr.f.index];
    assign tagRd  = tagArray[lookupAddr.f.index];

    // a stale tag never hits, valid gates the compare
    assign tagMatch = validBits[lookupAddr.f.index] && (tagRd == lookupAddr.f.tag);

    // word w lives in bits 32w+31 down to 32w
    assign wordRd = lineRd[lookupAddr.f.offset * `ICACHE_WORD_BITS +: `ICACHE_WORD_BITS];

    // hit and miss are single-cycle pulses per lookup
    always_ff @(posedge clk) begin
        if (reset) begin
            hit  <= 1'b0;
            miss <= 1'b0;
        end else begin
            hit  <= lookupEn && tagMatch;
            miss <= lookupEn && !tagMatch;
        end
    end

    // selected word, meaningful only while hit is high
    always_ff @(posedge clk) begin
        if (lookupEn) begin
            instrOut <= wordRd;
        end
    end

    // valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            validBits <= '0;
        end else if (loadLine) begin
            validBits[loadAddr.f.index] <= 1'b1;
        end
    end

    // line and tag written together in the load cycle
    // so a lookup on the next edge already sees them
    always_ff @(posedge clk) begin
        if (loadLine) begin
            dataArray[loadAddr.f.index] <= loadData;
            tagArray[loadAddr.f.index]  <= loadAddr.f.tag;
        end
    end

endmodule

/* refillCtrl.sv */
// one miss in flight; the memory must answer each memReq with exactly one memLineValid
`timescale 1ns/100ps
`include "icacheConsts.svh"

module refillCtrl (
    input  logic                         clk,
    input  logic                         reset,
    // core side
    input  logic                         en,
    input  logic [`ICACHE_ADDR_BITS-1:0] addr,
    output logic                         busy,
    output logic                         instrValid,
    // cache lookup results
    input  logic                         hit,
    input  logic                         miss,
    // cache lookup and line load
    output logic                         lookupEn,
    output icachePkg::fetchAddr          lookupAddr,
    output logic                         loadLine,
    output icachePkg::fetchAddr          loadAddr,
    output logic [`ICACHE_LINE_BITS-1:0] loadData,
    // memory side
    output logic                         memReq,
    output logic [`ICACHE_ADDR_BITS-1:0] memAddr,
    input  logic                         memLineValid,
    input  logic [`ICACHE_LINE_BITS-1:0] memLine
);

    localparam logic [2:0] stIdle    = 3'd0;
    localparam logic [2:0] stLookup  = 3'd1;
    localparam logic [2:0] stWaitMem = 3'd2;
    localparam logic [2:0] stLoad    = 3'd3;
    localparam logic [2:0] stReplay  = 3'd4;

    logic [2:0]                   state;
    logic [2:0]                   nextState;
    logic                         accept;
    // address of the fetch in flight, replayed after a refill
    icachePkg::fetchAddr          pending;
    icachePkg::fetchAddr          lineAddr;
    // line captured from memory, held for the load cycle
    logic [`ICACHE_LINE_BITS-1:0] lineBuf;

    // busy rises with the miss pulse and drops with the replay hit
    assign busy = (state == stLookup && miss) || (state == stWaitMem) ||
                  (state == stLoad) || (state == stReplay);

    // a fetch is taken when idle or right behind a hit
    assign accept     = en && !busy;
    assign memReq     = (state == stLookup) && miss;
    assign instrValid = (state == stLookup) && hit;

    // the lookup port carries either the core request or the replay
    assign lookupEn = accept || (state == stReplay);
    always_comb begin
        lookupAddr.raw = (state == stReplay) ? pending.raw : addr;
    end

    // line-aligned address for the memory, offset zeroed
    always_comb begin
        lineAddr          = pending;
        lineAddr.f.offset = '0;
    end

    assign loadLine = (state == stLoad);
    assign loadAddr = pending;
    assign loadData = lineBuf;

    always_comb begin
        nextState = state;
        case (state)
            stIdle:    if (accept) nextState = stLookup;
            stLookup: begin
                if (miss) nextState = stWaitMem;
                else if (accept) nextState = stLookup;
                else nextState = stIdle;
            end
            stWaitMem: if (memLineValid) nextState = stLoad;
            stLoad:    nextState = stReplay;
            // replay result comes back in stLookup and will hit
            stReplay:  nextState = stLookup;
            default:   nextState = stIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) state <= stIdle;
        else state <= nextState;
    end

    always_ff @(posedge clk) begin
        if (accept) pending.raw <= addr;
        // held steady until the next request
        if (memReq) memAddr <= lineAddr.raw;
        if (state == stWaitMem && memLineValid) lineBuf <= memLine;
    end

endmodule

/* fetchTop.sv */
// fetch side top; en is ignored while busy and instrValid cannot be stalled by the core
`timescale 1ns/100ps
`include "icacheConsts.svh"

module fetchTop (
    input  logic                         clk,
    input  logic                         reset,
    // core side
    input  logic                         en,
    input  logic [`ICACHE_ADDR_BITS-1:0] addr,
    output logic [`ICACHE_WORD_BITS-1:0] instrOut,
    output logic                         instrValid,
    output logic                         busy,
    // line memory side
    output logic                         memReq,
    output logic [`ICACHE_ADDR_BITS-1:0] memAddr,
    input  logic                         memLineValid,
    input  logic [`ICACHE_LINE_BITS-1:0] memLine
);

    // controller to cache
    logic                         lookupEn;
    icachePkg::fetchAddr          lookupAddr;
    logic                         loadLine;
    icachePkg::fetchAddr          loadAddr;
    logic [`ICACHE_LINE_BITS-1:0] loadData;
    // cache to controller
    logic                         hit;
    logic                         miss;

    // instrOut goes straight to the core, qualified by instrValid
    iCache cache (
        .clk(clk), .reset(reset),
        .lookupEn(lookupEn), .lookupAddr(lookupAddr),
        .loadLine(loadLine), .loadAddr(loadAddr), .loadData(loadData),
        .instrOut(instrOut), .hit(hit), .miss(miss)
    );

    refillCtrl ctrl (
        .clk(clk), .reset(reset),
        .en(en), .addr(addr), .busy(busy), .instrValid(instrValid),
        .hit(hit), .miss(miss),
        .lookupEn(lookupEn), .lookupAddr(lookupAddr),
        .loadLine(loadLine), .loadAddr(loadAddr), .loadData(loadData),
        .memReq(memReq), .memAddr(memAddr),
        .memLineValid(memLineValid), .memLine(memLine)
    );

endmodule

/* lineMemModel.sv */
// testbench line memory; one request at a time, latency of 1 or more, line data follows memAddr
`timescale 1ns/100ps
`include "icacheConsts.svh"

module lineMemModel #(
    parameter logic [`ICACHE_WORD_BITS-1:0] pattern = 32'h0
) (
    input  logic                         clk,
    input  logic                         reset,
    // cycles from the memReq cycle to the memLineValid cycle
    input  logic [7:0]                   latency,
    input  logic                         memReq,
    input  logic [`ICACHE_ADDR_BITS-1:0] memAddr,
    output logic                         memLineValid,
    output logic [`ICACHE_LINE_BITS-1:0] memLine
);

    logic [7:0] countdown;
    logic       waiting;

    // memAddr settles the cycle after memReq and then holds
    // word w of the line is (memAddr + w) ^ pattern
    always_comb begin
        for (int w = 0; w < `ICACHE_WORDS; w++) begin
            memLine[w*`ICACHE_WORD_BITS +: `ICACHE_WORD_BITS] = (memAddr + w) ^ pattern;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            memLineValid <= 1'b0;
            waiting      <= 1'b0;
            countdown    <= '0;
        end else begin
            memLineValid <= 1'b0;
            if (memReq) begin
                // latency of one answers in the very next cycle
                if (latency <= 8'd1) begin
                    memLineValid <= 1'b1;
                end else begin
                    waiting   <= 1'b1;
                    countdown <= latency - 8'd1;
                end
            end else if (waiting) begin
                if (countdown == 8'd1) begin
                    memLineValid <= 1'b1;
                    waiting      <= 1'b0;
                end
                countdown <= countdown - 8'd1;
            end
        end
    end

endmodule

/* fetchTb.sv */
// directed tests of the fetch path; one fetch at a time from the core, memory latency 1 to 20 cycles
`timescale 1ns/100ps
`include "icacheConsts.svh"

module fetchTb;

    // word w of line a is (a + w) ^ linePattern
    localparam logic [31:0] linePattern = 32'h5a3c_96e1;
    localparam int clkPeriod = 8;
    localparam int maxLatency = 20;
    // memory latency plus load, replay and result cycles and some slack
    localparam int worstMissCycles = maxLatency + 6;
    // all tests together issue fewer fetches than this
    localparam int numFetches = 240;
    localparam int maxWait = 64;
    localparam int timeoutNs = (numFetches * worstMissCycles + 100) * clkPeriod;

    logic                         clk;
    logic                         reset;
    logic                         en;
    logic [31:0]                  addr;
    logic [31:0]                  instrOut;
    logic                         instrValid;
    logic                         busy;
    logic                         memReq;
    logic [31:0]                  memAddr;
    logic                         memLineValid;
    logic [`ICACHE_LINE_BITS-1:0] memLine;
    logic [7:0]                   memLatency;
    integer                       seed;

    // lines the cache should hold right now
    logic                         resValid [`ICACHE_LINES];
    logic [`ICACHE_TAG_BITS-1:0]  resTag [`ICACHE_LINES];

    fetchTop UUT (
        .clk(clk), .reset(reset),
        .en(en), .addr(addr),
        .instrOut(instrOut), .instrValid(instrValid), .busy(busy),
        .memReq(memReq), .memAddr(memAddr),
        .memLineValid(memLineValid), .memLine(memLine)
    );

    lineMemModel #(.pattern(linePattern)) lineMem (
        .clk(clk), .reset(reset), .latency(memLatency),
        .memReq(memReq), .memAddr(memAddr),
        .memLineValid(memLineValid), .memLine(memLine)
    );

    always #(clkPeriod/2) clk = ~clk;

    // outputs are read and inputs driven 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic stopOnError(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "run stopped at the first mismatch");
        end
    endtask

    function automatic logic [31:0] lineAlign(input logic [31:0] a);
        icachePkg::fetchAddr x;
        x.raw = a;
        x.f.offset = '0;
        return x.raw;
    endfunction

    // word at offset w of the line that holds a
    function automatic logic [31:0] expectedWord(input logic [31:0] a);
        icachePkg::fetchAddr x;
        x.raw = a;
        return (lineAlign(a) + x.f.offset) ^ linePattern;
    endfunction

    function automatic bit isResident(input logic [31:0] a);
        icachePkg::fetchAddr x;
        x.raw = a;
        return resValid[x.f.index] && (resTag[x.f.index] == x.f.tag);
    endfunction

    task automatic applyReset();
        reset = 1'b1;
        en = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < `ICACHE_LINES; i++) begin
            resValid[i] = 1'b0;
        end
        checkValue(instrValid, 0, "instrValid after reset");
        checkValue(busy, 0, "busy after reset");
        checkValue(memReq, 0, "memReq after reset");
    endtask

    // stray fetches while busy must be ignored by the DUT
    task automatic driveWhileBusy(input bit poke);
        en = poke;
        if (poke) begin
            addr = $random(seed);
        end
    endtask

    task automatic expectRefillBusy(input logic [31:0] a, input string phase);
        checkValue(busy, 1, {"busy during ", phase});
        checkValue(memReq, 0, {"extra memReq during ", phase});
        checkValue(instrValid, 0, {"instrValid during ", phase});
        checkValue(memAddr, lineAlign(a), {"line-aligned memAddr during ", phase});
    endtask

    // one fetch whose hit or miss is predicted from the resident model
    task automatic fetchAndCompare(input logic [31:0] a, input bit poke);
        icachePkg::fetchAddr fa;
        bit expectMiss;
        int waited;
        fa.raw = a;
        expectMiss = !isResident(a);
        en = 1'b1;
        addr = a;
        tick();
        en = 1'b0;
        if (!expectMiss) begin
            checkValue(instrValid, 1, "instrValid one cycle after a hitting fetch");
            checkValue(memReq, 0, "memReq on a hit");
            checkValue(busy, 0, "busy on a hit");
            checkValue(instrOut, expectedWord(a), "instruction word on a hit");
        end else begin
            checkValue(busy, 1, "busy one cycle after a missing fetch");
            checkValue(memReq, 1, "memReq one cycle after a missing fetch");
            checkValue(instrValid, 0, "instrValid on a miss");
            waited = 0;
            driveWhileBusy(poke);
            tick();
            while (!memLineValid) begin
                expectRefillBusy(a, "the memory wait");
                if (waited == maxWait) begin
                    stopOnError("the line memory never answered the request");
                end
                driveWhileBusy(poke);
                tick();
                waited++;
            end
            // instrValid lands exactly three cycles after memLineValid
            expectRefillBusy(a, "line arrival");
            driveWhileBusy(poke);
            tick();
            expectRefillBusy(a, "line load");
            driveWhileBusy(poke);
            tick();
            expectRefillBusy(a, "replay");
            en = 1'b0;
            tick();
            checkValue(instrValid, 1, "instrValid three cycles after memLineValid");
            checkValue(busy, 0, "busy with the replay hit");
            checkValue(memReq, 0, "memReq with the replay hit");
            checkValue(instrOut, expectedWord(a), "instruction word after refill");
            resValid[fa.f.index] = 1'b1;
            resTag[fa.f.index] = fa.f.tag;
        end
    endtask

    task automatic coldMissTest();
        fetchAndCompare(32'h0000_1234, 1'b0);
    endtask

    // every offset of the line just filled hits
    task automatic hitSweepTest();
        for (int w = 0; w < `ICACHE_WORDS; w++) begin
            fetchAndCompare(lineAlign(32'h0000_1234) + w, 1'b0);
        end
    endtask

    task automatic tagConflictTest();
        icachePkg::fetchAddr a0;
        icachePkg::fetchAddr a1;
        a0.f.tag = 21'h00042;
        a0.f.index = 7'd37;
        a0.f.offset = 4'd3;
        a1.raw = a0.raw;
        a1.f.tag = 21'h1f00d;
        a1.f.offset = 4'd11;
        // same index, so each fetch evicts the other line
        for (int i = 0; i < 3; i++) begin
            fetchAndCompare(a0.raw, 1'b0);
            fetchAndCompare(a1.raw, 1'b0);
        end
        // the last line loaded stays put
        fetchAndCompare(a1.raw + 32'd1, 1'b0);
    endtask

    task automatic latencyTest();
        logic [31:0] base;
        for (int i = 0; i < 3; i++) begin
            memLatency = (i == 0) ? 8'd1 : (i == 1) ? 8'd5 : 8'd20;
            base = 32'h0010_0000 + (i << 4);
            fetchAndCompare(base + 32'd2, 1'b1);
            fetchAndCompare(base + 32'd9, 1'b0);
        end
        memLatency = 8'd2;
    endtask

    task automatic resetClearsTest();
        fetchAndCompare(32'h0000_1234, 1'b0);
        fetchAndCompare(32'h0010_0005, 1'b0);
        applyReset();
        // both lines were resident and must now miss
        fetchAndCompare(32'h0000_1234, 1'b0);
        fetchAndCompare(32'h0010_0005, 1'b0);
    endtask

    task automatic randomSweepTest();
        icachePkg::fetchAddr ra;
        logic [31:0] rnd;
        for (int n = 0; n < 200; n++) begin
            ra.raw = $random(seed);
            // two tags over sixteen lines gives plenty of hits and conflicts
            ra.f.tag = ra.f.tag & 21'h1;
            ra.f.index = ra.f.index & 7'h0f;
            rnd = $random(seed);
            memLatency = 8'd1 + {5'd0, rnd[2:0]};
            fetchAndCompare(ra.raw, rnd[3]);
        end
    endtask

    initial begin
        #(timeoutNs);
        stopOnError("watchdog expired before the tests finished");
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        en = 1'b0;
        addr = '0;
        memLatency = 8'd2;
        seed = 32'h593f;
        applyReset();
        coldMissTest();
        hitSweepTest();
        tagConflictTest();
        latencyTest();
        resetClearsTest();
        randomSweepTest();
        $display("Verification passed");
        $finish;
    end

endmodule

/* list.f */
+incdir+.
icachePkg.sv
iCache.sv
refillCtrl.sv
fetchTop.sv
lineMemModel.sv
fetchTb.sv
